// File: rtl/axird_params.svh
// Bus widths and FIFO sizing that the package, RTL and testbench of the AXI read bridge include
`ifndef AXIRD_PARAMS_SVH
`define AXIRD_PARAMS_SVH

`define AXIRD_DATA_W     32
`define AXIRD_ADDR_W     32
`define AXIRD_ID_W       4
`define AXIRD_USER_W     4

// Depth must stay a power of two
`define AXIRD_FIFO_DEPTH 16
`define AXIRD_PTR_W      4

// Holds depth plus one full 256-beat burst
`define AXIRD_CREDIT_W   10

`endif

// File: rtl/axird_pkg.sv
// Channel beat types shared by the AXI read bridge RTL and its testbench
`default_nettype none

`include "axird_params.svh"

package axird_pkg;

    // One AR channel beat
    typedef struct packed {
        logic [`AXIRD_ID_W-1:0]   id;
        logic [`AXIRD_ADDR_W-1:0] addr;
        logic [7:0]               len;
        logic [2:0]               size;
        logic [1:0]               burst;
        logic                     lock;
        logic [3:0]               cache;
        logic [2:0]               prot;
        logic [3:0]               qos;
        logic [3:0]               region;
        logic [`AXIRD_USER_W-1:0] user;
    } ar_beat_t;

    // One R channel beat
    typedef struct packed {
        logic [`AXIRD_ID_W-1:0]   id;
        logic [`AXIRD_DATA_W-1:0] data;
        logic [1:0]               resp;
        logic                     last;
        logic [`AXIRD_USER_W-1:0] user;
    } r_beat_t;

endpackage

`default_nettype wire

// File: rtl/axird_ar_gate_fsm.sv
// Read-address gate that holds each accepted AR beat until the credit counter reports room
`timescale 1ns/10ps
`default_nettype none

module axird_ar_gate_fsm (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire axird_pkg::ar_beat_t s_ar,
    input  wire logic               s_arvalid,
    output logic                    s_arready,
    output axird_pkg::ar_beat_t     m_ar,
    output logic                    m_arvalid,
    input  wire logic               m_arready,
    input  wire logic               room,
    output logic                    grant,
    output logic [7:0]              grant_len
);

    typedef enum logic {IDLE, WAIT} state_t;

    state_t              state_q, state_d;
    logic                s_arready_q, s_arready_d;
    logic                m_arvalid_q, m_arvalid_d;
    logic                load_ar;
    axird_pkg::ar_beat_t ar_q;

    // Length under test is the held beat while waiting, else the incoming one
    assign grant_len = (state_q == WAIT) ? ar_q.len : s_ar.len;

    always_comb begin
        state_d     = state_q;
        s_arready_d = s_arready_q;
        m_arvalid_d = m_arvalid_q && !m_arready;
        grant       = 1'b0;
        load_ar     = 1'b0;

        case (state_q)
            IDLE: begin
                s_arready_d = !m_arvalid_q;
                if (s_arvalid && s_arready_q) begin
                    s_arready_d = 1'b0;
                    load_ar     = 1'b1;
                    if (room) begin
                        grant       = 1'b1;
                        m_arvalid_d = 1'b1;
                    end else begin
                        state_d = WAIT;
                    end
                end
            end
            WAIT: begin
                s_arready_d = 1'b0;
                if (room) begin
                    grant       = 1'b1;
                    m_arvalid_d = 1'b1;
                    state_d     = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= IDLE;
            s_arready_q <= 1'b0;
            m_arvalid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            s_arready_q <= s_arready_d;
            m_arvalid_q <= m_arvalid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_ar) begin
            ar_q <= s_ar;
        end
    end

    assign s_arready = s_arready_q;
    assign m_arvalid = m_arvalid_q;
    assign m_ar      = ar_q;

endmodule

`default_nettype wire

// File: rtl/axird_burst_credit.sv
// Tracks FIFO slots reserved by forwarded bursts and decides whether the next burst fits
`timescale 1ns/10ps
`default_nettype none

`include "axird_params.svh"

module axird_burst_credit (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       grant,
    input  wire logic [7:0] grant_len,
    input  wire logic       pop,
    output logic            room
);

    logic [`AXIRD_CREDIT_W-1:0] count_q;
    logic [`AXIRD_CREDIT_W-1:0] burst_beats;
    logic [`AXIRD_CREDIT_W-1:0] add_beats;
    logic [`AXIRD_CREDIT_W-1:0] sub_beats;

    assign burst_beats = {{(`AXIRD_CREDIT_W-8){1'b0}}, grant_len} + 1'b1;
    assign add_beats   = grant ? burst_beats : '0;
    assign sub_beats   = {{(`AXIRD_CREDIT_W-1){1'b0}}, pop};

    // Nothing outstanding lets any burst through including one larger than the FIFO
    assign room = (count_q == '0) || (count_q + burst_beats <= `AXIRD_FIFO_DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + add_beats - sub_beats;
        end
    end

endmodule

`default_nettype wire

// File: rtl/axird_r_fifo.sv
// Read-beat FIFO with a prefetch stage and registered upstream output
`timescale 1ns/10ps
`default_nettype none

`include "axird_params.svh"

module axird_r_fifo (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire axird_pkg::r_beat_t m_r,
    input  wire logic              m_rvalid,
    output logic                   m_rready,
    output axird_pkg::r_beat_t     s_r,
    output logic                   s_rvalid,
    input  wire logic              s_rready,
    output logic                   pop
);

    axird_pkg::r_beat_t mem [`AXIRD_FIFO_DEPTH];

    // Extra top bit tells full from empty
    logic [`AXIRD_PTR_W:0] wr_ptr_q;
    logic [`AXIRD_PTR_W:0] rd_ptr_q;

    logic               full;
    logic               empty;
    logic               write;
    logic               read;
    logic               load_out;
    logic               pf_valid_q;
    axird_pkg::r_beat_t pf_q;
    logic               s_rvalid_q;
    axird_pkg::r_beat_t s_r_q;

    assign full  = (wr_ptr_q[`AXIRD_PTR_W] != rd_ptr_q[`AXIRD_PTR_W]) &&
                   (wr_ptr_q[`AXIRD_PTR_W-1:0] == rd_ptr_q[`AXIRD_PTR_W-1:0]);
    assign empty = (wr_ptr_q == rd_ptr_q);

    assign m_rready = !full;
    assign write    = m_rvalid && !full;

    // Output register takes a new beat when empty or draining
    assign load_out = s_rready || !s_rvalid_q;
    assign read     = (load_out || !pf_valid_q) && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
        end else if (write) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr_q[`AXIRD_PTR_W-1:0]] <= m_r;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr_q   <= '0;
            pf_valid_q <= 1'b0;
            s_rvalid_q <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (load_out || !pf_valid_q) begin
                pf_valid_q <= !empty;
            end
            if (load_out) begin
                s_rvalid_q <= pf_valid_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            pf_q <= mem[rd_ptr_q[`AXIRD_PTR_W-1:0]];
        end
        if (load_out) begin
            s_r_q <= pf_q;
        end
    end

    assign s_r      = s_r_q;
    assign s_rvalid = s_rvalid_q;
    assign pop      = s_rvalid_q && s_rready;

endmodule

`default_nettype wire

// File: rtl/axird_bridge.sv
// Top level of the AXI4 read bridge that sits between a read master and a read slave
`timescale 1ns/10ps
`default_nettype none

module axird_bridge (
    input  wire logic               clk,
    input  wire logic               rst,

    // Upstream, facing the read master
    input  wire axird_pkg::ar_beat_t s_ar,
    input  wire logic               s_arvalid,
    output logic                    s_arready,
    output axird_pkg::r_beat_t      s_r,
    output logic                    s_rvalid,
    input  wire logic               s_rready,

    // Downstream, facing the read slave
    output axird_pkg::ar_beat_t     m_ar,
    output logic                    m_arvalid,
    input  wire logic               m_arready,
    input  wire axird_pkg::r_beat_t  m_r,
    input  wire logic               m_rvalid,
    output logic                    m_rready
);

    logic       grant;
    logic [7:0] grant_len;
    logic       room;
    logic       pop;

    axird_ar_gate_fsm u_ar_gate (
        .clk       (clk),
        .rst       (rst),
        .s_ar      (s_ar),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .m_ar      (m_ar),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .room      (room),
        .grant     (grant),
        .grant_len (grant_len)
    );

    axird_burst_credit u_credit (
        .clk       (clk),
        .rst       (rst),
        .grant     (grant),
        .grant_len (grant_len),
        .pop       (pop),
        .room      (room)
    );

    axird_r_fifo u_r_fifo (
        .clk      (clk),
        .rst      (rst),
        .m_r      (m_r),
        .m_rvalid (m_rvalid),
        .m_rready (m_rready),
        .s_r      (s_r),
        .s_rvalid (s_rvalid),
        .s_rready (s_rready),
        .pop      (pop)
    );

endmodule

`default_nettype wire

// File: dv/axird_bridge_chk.sv
// Handshake and reset assertions that the testbench binds into the AXI read bridge top level
`timescale 1ns/10ps
`default_nettype none

module axird_bridge_chk (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                s_arready,
    input wire axird_pkg::r_beat_t  s_r,
    input wire logic                s_rvalid,
    input wire logic                s_rready,
    input wire axird_pkg::ar_beat_t m_ar,
    input wire logic                m_arvalid,
    input wire logic                m_arready
);

    // Stays high once any assertion has failed
    logic assert_fired = 1'b0;

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar))
        else begin
            $error("m_arvalid dropped or m_ar changed before m_arready");
            assert_fired = 1'b1;
        end

    r_stable: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_r))
        else begin
            $error("s_rvalid dropped or s_r changed before s_rready");
            assert_fired = 1'b1;
        end

    // Control outputs quiet in the cycle after reset
    reset_quiet: assert property (@(posedge clk) rst |=> !s_rvalid && !m_arvalid && !s_arready)
        else begin
            $error("control output active in the cycle after reset");
            assert_fired = 1'b1;
        end

endmodule

`default_nettype wire

// File: dv/axird_bridge_tb.sv
// Testbench for the AXI read bridge with a random upstream master and a downstream slave model
`timescale 1ns/10ps
`default_nettype none

`include "axird_params.svh"

module axird_bridge_tb;

    localparam int NUM_BURSTS  = 200;
    localparam int CYCLE_LIMIT = NUM_BURSTS * 32 * 8 + 1000;

    logic                clk;
    logic                rst;
    logic                s_arvalid, s_arready, s_rvalid, s_rready;
    logic                m_arvalid, m_arready, m_rvalid, m_rready;
    axird_pkg::ar_beat_t s_ar, m_ar;
    axird_pkg::r_beat_t  s_r, m_r;

    // Requests waiting for forwarding, for upstream data, and inside the slave model
    axird_pkg::ar_beat_t acc_q[$], up_q[$], slv_q[$];
    logic [31:0]         rng = 32'hb7ad_92a0;
    int                  issued = 0, bursts_done = 0, big_done = 0, rd_idx = 0, slv_idx = 0;
    int                  hold_left = 0, outstanding = 0, cycles = 0;
    bit                  s_ar_fire = 1'b0, m_r_fire = 1'b0, rready_dropped = 1'b0;

    axird_bridge uut (.*);
    bind axird_bridge axird_bridge_chk u_chk (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // Beat idx of burst ar as the slave returns it and upstream must see it
    function automatic axird_pkg::r_beat_t ref_beat(axird_pkg::ar_beat_t ar, int idx);
        axird_pkg::r_beat_t b;
        b.id   = ar.id;
        b.data = (ar.addr + 4 * idx) ^ {(`AXIRD_DATA_W / `AXIRD_USER_W){ar.user}};
        b.resp = 2'(ar.addr + idx);
        b.last = idx == int'(ar.len);
        b.user = ar.user;
        return b;
    endfunction

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_ar(string name, axird_pkg::ar_beat_t expected,
                              axird_pkg::ar_beat_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic compare_r(string name, axird_pkg::r_beat_t expected,
                             axird_pkg::r_beat_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    initial begin : stimulus_proc
        logic [31:0] r;
        logic [95:0] rnd_ar;
        clk  = 1'b0;
        rst  = 1'b1;
        s_ar = '0;
        m_r  = '0;
        {s_arvalid, s_rready, m_arready, m_rvalid} = 4'b0000;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (bursts_done < NUM_BURSTS) begin
            @(negedge clk);
            // Next request only once the previous one was taken
            if (s_ar_fire || !s_arvalid) begin
                s_arvalid = issued < NUM_BURSTS && next_rand() >= 32'h4000_0000;
                if (s_arvalid) begin
                    rnd_ar        = {next_rand(), next_rand(), next_rand()};
                    s_ar          = rnd_ar[$bits(s_ar)-1:0];
                    s_ar.len[7:5] = 3'b000;
                    issued        = issued + 1;
                end
            end
            m_arready = next_rand() >= 32'h4000_0000;
            // Slave model walks the oldest forwarded burst
            if (m_r_fire) begin
                slv_idx = (slv_idx == int'(slv_q[0].len)) ? 0 : slv_idx + 1;
                if (slv_idx == 0) begin
                    void'(slv_q.pop_front());
                end
            end
            if (m_r_fire || !m_rvalid) begin
                m_rvalid = slv_q.size() != 0 && next_rand() >= 32'h4000_0000;
                if (m_rvalid) begin
                    m_r = ref_beat(slv_q[0], slv_idx);
                end
            end
            // Rare long stretches of s_rready low so the FIFO fills
            r = next_rand();
            if (hold_left > 0) begin
                hold_left = hold_left - 1;
            end else if (r[31:25] == 7'd0) begin
                hold_left = 40 + int'(r[24:20]);
            end
            s_rready = hold_left == 0 && next_rand() >= 32'h4000_0000;
        end
        repeat (4) @(negedge clk);
        if (uut.u_chk.assert_fired) begin
            $display("A handshake or reset assertion in the bound checker failed");
            stop_run();
        end else if (!rready_dropped || big_done == 0) begin
            $display("FIFO never filled under back-pressure or no oversized burst completed");
            stop_run();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

    always @(posedge clk) begin : compare_proc
        axird_pkg::r_beat_t exp_r;
        cycles = cycles + 1;
        if (uut.u_chk.assert_fired) begin
            $display("A handshake or reset assertion in the bound checker failed");
            stop_run();
        end
        if (cycles > CYCLE_LIMIT) begin
            $display("Run hung: %0d of %0d bursts finished", bursts_done, NUM_BURSTS);
            stop_run();
        end
        s_ar_fire = !rst && s_arvalid && s_arready;
        m_r_fire  = !rst && m_rvalid && m_rready;
        if (!rst && !m_rready) begin
            rready_dropped = 1'b1;
        end
        if (s_ar_fire) begin
            acc_q.push_back(s_ar);
            up_q.push_back(s_ar);
        end
        if (!rst && m_arvalid && m_arready) begin
            compare_ar("address forwarding", acc_q.pop_front(), m_ar);
            if (outstanding != 0 && outstanding + m_ar.len + 1 > `AXIRD_FIFO_DEPTH) begin
                $display("FIFO space overcommitted: %0d-beat burst forwarded with %0d outstanding",
                         m_ar.len + 1, outstanding);
                stop_run();
            end
            outstanding = outstanding + m_ar.len + 1;
            slv_q.push_back(m_ar);
        end
        if (!rst && s_rvalid && s_rready) begin
            exp_r = ref_beat(up_q[0], rd_idx);
            compare_r($sformatf("read data burst %0d beat %0d", bursts_done, rd_idx), exp_r, s_r);
            outstanding = outstanding - 1;
            rd_idx      = rd_idx + 1;
            if (exp_r.last) begin
                big_done    = big_done + int'(up_q[0].len > 15);
                bursts_done = bursts_done + 1;
                rd_idx      = 0;
                void'(up_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/axird_pkg.sv
rtl/axird_ar_gate_fsm.sv
rtl/axird_burst_credit.sv
rtl/axird_r_fifo.sv
rtl/axird_bridge.sv
dv/axird_bridge_chk.sv
dv/axird_bridge_tb.sv

// File: Bender.yml
package:
  name: axird_bridge

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axird_pkg.sv
      - rtl/axird_ar_gate_fsm.sv
      - rtl/axird_burst_credit.sv
      - rtl/axird_r_fifo.sv
      - rtl/axird_bridge.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/axird_bridge_chk.sv
      - dv/axird_bridge_tb.sv
